//--- hdl/stream_pkg.sv
package stream_pkg;

  // stream side widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned CNT_W  = 16;  // transfer counter width

  // one beat from the engine
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } stream_beat_t;

  // two-level address pattern
  typedef struct packed {
    logic [31:0]      base_addr;  // byte address of first beat
    logic [CNT_W-1:0] tot_len;    // beats in the whole transfer
    logic [CNT_W-1:0] d0_len;     // beats per line
    logic [15:0]      d0_stride;  // byte step inside a line
    logic [31:0]      d1_stride;  // byte step between lines
  } addrgen_ctrl_t;

  typedef struct packed {
    logic done;  // last address pushed
  } addrgen_flags_t;

  // control plane of the sink
  typedef struct packed {
    logic          req_start;
    addrgen_ctrl_t addrgen_ctrl;
  } sink_ctrl_t;

  typedef struct packed {
    logic           ready_start;    // idle and able to take a start
    logic           done;           // one cycle pulse at the end
    addrgen_flags_t addrgen_flags;
  } sink_flags_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,  // generator still running
    DRAIN   = 2'd2   // wait for the last beats
  } sink_state_e;

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

  // memory side widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned OFFS_W     = 2;                      // byte in a word
  localparam int unsigned WORD_W     = ADDR_W - OFFS_W;
  localparam int unsigned MEM_DATA_W = stream_pkg::DATA_W + 32; // room for a shifted beat
  localparam int unsigned MEM_BE_W   = MEM_DATA_W / 8;

  // byte address, or word index plus byte offset
  typedef union packed {
    logic [ADDR_W-1:0] byte_addr;
    struct packed {
      logic [WORD_W-1:0] word;
      logic [OFFS_W-1:0] offset;
    } split;
  } mem_addr_u;

  // one store on the scratchpad port
  typedef struct packed {
    logic [ADDR_W-1:0]     add;   // word aligned
    logic                  wen;   // 0 for a write
    logic [MEM_BE_W-1:0]   be;
    logic [MEM_DATA_W-1:0] data;
  } mem_req_t;

endpackage

//--- hdl/sink_addressgen.sv
`timescale 1ns/100ps

module sink_addressgen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  stream_pkg::addrgen_ctrl_t ctrl_i,
  output mem_pkg::mem_addr_u        addr_o,
  output logic                      addr_valid_o,
  input  logic                      addr_ready_i,
  output stream_pkg::addrgen_flags_t flags_o
);

  // pattern sampled at start
  logic [stream_pkg::CNT_W-1:0] tot_len_q;
  logic [stream_pkg::CNT_W-1:0] d0_len_q;
  logic [15:0]                  d0_stride_q;
  logic [31:0]                  d1_stride_q;

  logic                         run_q;    // addresses left to send
  logic                         done_q;
  logic [stream_pkg::CNT_W-1:0] cnt_q;    // addresses pushed so far
  logic [stream_pkg::CNT_W-1:0] inner_q;  // index inside the line
  logic [mem_pkg::ADDR_W-1:0]   line_q;   // start of current line
  logic [mem_pkg::ADDR_W-1:0]   offs_q;   // offset inside the line

  logic push;
  logic last_beat;
  logic last_inner;

  assign push       = run_q & addr_ready_i;
  assign last_beat  = cnt_q == tot_len_q - 1'b1;
  assign last_inner = inner_q == d0_len_q - 1'b1;

  assign addr_o.byte_addr = line_q + offs_q;
  assign addr_valid_o     = run_q;
  assign flags_o.done     = done_q;

  always_ff @(posedge clk_i) begin
    if (start_i) begin  // pattern for the whole transfer
      tot_len_q   <= ctrl_i.tot_len;
      d0_len_q    <= ctrl_i.d0_len;
      d0_stride_q <= ctrl_i.d0_stride;
      d1_stride_q <= ctrl_i.d1_stride;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q   <= 1'b0;
      done_q  <= 1'b0;
      cnt_q   <= '0;
      inner_q <= '0;
      line_q  <= '0;
      offs_q  <= '0;
    end else if (clear_i) begin
      run_q   <= 1'b0;
      done_q  <= 1'b0;
      cnt_q   <= '0;
      inner_q <= '0;
      line_q  <= '0;
      offs_q  <= '0;
    end else if (start_i) begin
      run_q   <= 1'b1;  // first address next cycle
      done_q  <= 1'b0;
      cnt_q   <= '0;
      inner_q <= '0;
      line_q  <= ctrl_i.base_addr;
      offs_q  <= '0;
    end else if (push) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_beat) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;  // held until the sink clears us
      end
      if (last_inner) begin  // next line
        inner_q <= '0;
        offs_q  <= '0;
        line_q  <= line_q + d1_stride_q;
      end else begin
        inner_q <= inner_q + 1'b1;
        offs_q  <= offs_q + {{(mem_pkg::ADDR_W-16){1'b0}}, d0_stride_q};
      end
    end
  end

  // the fifo may sample addr a few cycles after valid rose
  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o)
  );

endmodule

//--- hdl/addr_fifo.sv
`timescale 1ns/100ps

module addr_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  mem_pkg::mem_addr_u push_data_i,
  input  logic               push_valid_i,
  output logic               push_ready_o,
  output mem_pkg::mem_addr_u pop_data_o,
  output logic               pop_valid_o,
  input  logic               pop_ready_i
);

  mem_pkg::mem_addr_u mem_q [2];
  logic [1:0]         wr_ptr_q;  // bit 1 is the wrap bit
  logic [1:0]         rd_ptr_q;

  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  assign empty = wr_ptr_q == rd_ptr_q;
  assign full  = (wr_ptr_q[0] == rd_ptr_q[0]) && (wr_ptr_q[1] != rd_ptr_q[1]);

  assign push_ready_o = ~full;
  assign pop_valid_o  = ~empty;
  assign pop_data_o   = mem_q[rd_ptr_q[0]];

  assign do_push = push_valid_i & push_ready_o;
  assign do_pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[0]] <= push_data_i;  // visible at the output next cycle
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // drop whatever is left
      rd_ptr_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // a push offered while full leaves the write side alone
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    full && push_valid_i |=> $stable(wr_ptr_q)
  );

  // a pop asked while empty leaves the read side alone
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    empty && pop_ready_i |=> $stable(rd_ptr_q)
  );

endmodule

//--- hdl/mem_req_fifo.sv
`timescale 1ns/100ps

module mem_req_fifo #(
  parameter int unsigned DEPTH = 2  // 0 gives a plain wire
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  mem_pkg::mem_req_t in_req_i,
  input  logic              in_valid_i,
  output logic              in_gnt_o,
  output mem_pkg::mem_req_t out_req_o,
  output logic              out_valid_o,
  input  logic              out_gnt_i
);

  if (DEPTH == 0) begin : g_bypass
    assign out_req_o   = in_req_i;
    assign out_valid_o = in_valid_i;
    assign in_gnt_o    = out_gnt_i;  // grant comes straight from memory
  end else begin : g_fifo
    localparam int unsigned IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned USE_W = $clog2(DEPTH + 1);

    mem_pkg::mem_req_t mem_q [DEPTH];
    logic [IDX_W-1:0]  wr_idx_q;
    logic [IDX_W-1:0]  rd_idx_q;
    logic [USE_W-1:0]  used_q;  // entries held

    logic do_push;
    logic do_pop;

    assign in_gnt_o    = used_q != USE_W'(DEPTH);
    assign out_valid_o = used_q != '0;
    assign out_req_o   = mem_q[rd_idx_q];  // stable until popped

    assign do_push = in_valid_i & in_gnt_o;
    assign do_pop  = out_valid_o & out_gnt_i;

    always_ff @(posedge clk_i) begin
      if (do_push) mem_q[wr_idx_q] <= in_req_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_idx_q <= '0;
        rd_idx_q <= '0;
        used_q   <= '0;
      end else if (clear_i) begin
        wr_idx_q <= '0;
        rd_idx_q <= '0;
        used_q   <= '0;
      end else begin
        if (do_push) wr_idx_q <= (wr_idx_q == IDX_W'(DEPTH-1)) ? '0 : wr_idx_q + 1'b1;
        if (do_pop)  rd_idx_q <= (rd_idx_q == IDX_W'(DEPTH-1)) ? '0 : rd_idx_q + 1'b1;
        if (do_push && !do_pop)      used_q <= used_q + 1'b1;
        else if (do_pop && !do_push) used_q <= used_q - 1'b1;
      end
    end
  end

endmodule

//--- hdl/stream_sink.sv
`timescale 1ns/100ps

module stream_sink (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  stream_pkg::sink_ctrl_t   ctrl_i,
  output stream_pkg::sink_flags_t  flags_o,
  input  logic                     gen_done_i,
  output logic                     gen_start_o,
  output logic                     gen_clear_o,
  input  mem_pkg::mem_addr_u       addr_i,
  input  logic                     addr_valid_i,
  output logic                     addr_ready_o,
  input  stream_pkg::stream_beat_t beat_i,
  input  logic                     beat_valid_i,
  output logic                     beat_ready_o,
  output mem_pkg::mem_req_t        req_o,
  output logic                     req_valid_o,
  input  logic                     gnt_i
);

  stream_pkg::sink_state_e state_q;
  stream_pkg::sink_state_e state_d;

  logic [stream_pkg::CNT_W-1:0] beat_cnt_q;  // addresses popped
  logic [stream_pkg::CNT_W-1:0] tot_len_q;
  logic                         done_q;

  logic active;
  logic start;
  logic finish;
  logic pop;

  mem_pkg::mem_addr_u              word_addr;   // addr with offset cleared
  logic [mem_pkg::MEM_DATA_W-1:0] data_shift;
  logic [mem_pkg::MEM_BE_W-1:0]   be_shift;

  assign active = state_q != stream_pkg::IDLE;
  assign start  = ctrl_i.req_start & ~active;
  assign finish = (state_q == stream_pkg::DRAIN) && (beat_cnt_q == tot_len_q);

  assign gen_start_o = start;
  assign gen_clear_o = clear_i | finish;  // generator restarts clean

  // beat and address leave together on a grant
  assign beat_ready_o = ~beat_valid_i | (gnt_i & addr_valid_i & active);
  assign addr_ready_o = beat_valid_i & beat_ready_o & active;
  assign pop          = addr_valid_i & addr_ready_o;
  assign req_valid_o  = active & beat_valid_i & addr_valid_i;

  // byte k goes to byte offset+k of the wide word
  assign data_shift = {{(mem_pkg::MEM_DATA_W-stream_pkg::DATA_W){1'b0}}, beat_i.data}
                      << {addr_i.split.offset, 3'b000};
  assign be_shift   = {{(mem_pkg::MEM_BE_W-stream_pkg::STRB_W){1'b0}}, beat_i.strb}
                      << addr_i.split.offset;

  always_comb begin
    word_addr              = addr_i;
    word_addr.split.offset = '0;
  end

  always_comb begin
    req_o = '0;  // quiet bus while idle
    if (active) begin
      req_o.add  = word_addr.byte_addr;
      req_o.wen  = 1'b0;  // writes only
      req_o.be   = be_shift;
      req_o.data = data_shift;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      stream_pkg::IDLE:    if (start) state_d = stream_pkg::WORKING;
      stream_pkg::WORKING: if (gen_done_i) state_d = stream_pkg::DRAIN;
      stream_pkg::DRAIN:   if (finish) state_d = stream_pkg::IDLE;
      default:             state_d = stream_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (start) tot_len_q <= ctrl_i.addrgen_ctrl.tot_len;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= stream_pkg::IDLE;
      done_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= stream_pkg::IDLE;  // abort without done
      done_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;  // high in first idle cycle
      if (start || finish) beat_cnt_q <= '0;
      else if (pop)        beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  assign flags_o.ready_start        = ~active;
  assign flags_o.done               = done_q;
  assign flags_o.addrgen_flags.done = gen_done_i;

  // relies on the engine and the addr fifo holding their outputs too
  a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    req_valid_o && !gnt_i |=> req_valid_o && $stable(req_o.add)
                              && $stable(req_o.be) && $stable(req_o.data)
  );

endmodule

//--- hdl/sink_top.sv
`timescale 1ns/100ps

module sink_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  stream_pkg::sink_ctrl_t   ctrl_i,
  output stream_pkg::sink_flags_t  flags_o,
  input  stream_pkg::stream_beat_t beat_i,
  input  logic                     beat_valid_i,
  output logic                     beat_ready_o,
  output mem_pkg::mem_req_t        mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_gnt_i
);

  mem_pkg::mem_addr_u         gen_addr;
  logic                       gen_addr_valid;
  logic                       gen_addr_ready;
  mem_pkg::mem_addr_u         fifo_addr;
  logic                       fifo_addr_valid;
  logic                       fifo_addr_ready;
  stream_pkg::addrgen_flags_t gen_flags;
  logic                       gen_start;
  logic                       gen_clear;  // includes clear_i
  mem_pkg::mem_req_t          sink_req;
  logic                       sink_req_valid;
  logic                       sink_gnt;

  sink_addressgen i_addressgen (
    .clk_i        ( clk_i               ),
    .rst_ni       ( rst_ni              ),
    .clear_i      ( gen_clear           ),
    .start_i      ( gen_start           ),
    .ctrl_i       ( ctrl_i.addrgen_ctrl ),
    .addr_o       ( gen_addr            ),
    .addr_valid_o ( gen_addr_valid      ),
    .addr_ready_i ( gen_addr_ready      ),
    .flags_o      ( gen_flags           )
  );

  addr_fifo i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_data_i  ( gen_addr        ),
    .push_valid_i ( gen_addr_valid  ),
    .push_ready_o ( gen_addr_ready  ),
    .pop_data_o   ( fifo_addr       ),
    .pop_valid_o  ( fifo_addr_valid ),
    .pop_ready_i  ( fifo_addr_ready )
  );

  stream_sink i_sink (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .ctrl_i       ( ctrl_i          ),
    .flags_o      ( flags_o         ),
    .gen_done_i   ( gen_flags.done  ),
    .gen_start_o  ( gen_start       ),
    .gen_clear_o  ( gen_clear       ),
    .addr_i       ( fifo_addr       ),
    .addr_valid_i ( fifo_addr_valid ),
    .addr_ready_o ( fifo_addr_ready ),
    .beat_i       ( beat_i          ),
    .beat_valid_i ( beat_valid_i    ),
    .beat_ready_o ( beat_ready_o    ),
    .req_o        ( sink_req        ),
    .req_valid_o  ( sink_req_valid  ),
    .gnt_i        ( sink_gnt        )
  );

  // decouples a slow grant from the stream
  mem_req_fifo #(
    .DEPTH ( 2 )
  ) i_req_fifo (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .clear_i     ( clear_i         ),
    .in_req_i    ( sink_req        ),
    .in_valid_i  ( sink_req_valid  ),
    .in_gnt_o    ( sink_gnt        ),
    .out_req_o   ( mem_req_o       ),
    .out_valid_o ( mem_req_valid_o ),
    .out_gnt_i   ( mem_gnt_i       )
  );

endmodule

//--- tests/tb_sink_top.sv
`timescale 1ns/100ps

module tb_sink_top;

  localparam int TIMEOUT   = 2000;  // cycles per wait
  localparam int MEM_BYTES = 4096;
  localparam int N_TESTS   = 8;

  typedef struct packed {
    stream_pkg::addrgen_ctrl_t pat;
    logic                      rnd_gnt;   // grant from the xorshift stream
    logic [15:0]               clear_at;  // clear at this beat when nonzero
  } test_row_t;

  logic                     clk = 1'b0;
  logic                     rst_n = 1'b0;
  logic                     clear = 1'b0;
  stream_pkg::sink_ctrl_t   ctrl = '0;
  stream_pkg::sink_flags_t  flags;
  stream_pkg::stream_beat_t beat = '0;
  logic                     beat_valid = 1'b0;
  logic                     beat_ready;
  mem_pkg::mem_req_t        mem_req;
  logic                     mem_req_valid;
  logic                     mem_gnt = 1'b0;

  test_row_t                 tbl [N_TESTS];
  logic [7:0]                mem [MEM_BYTES];      // scratchpad model
  logic [7:0]                exp_mem [MEM_BYTES];
  logic [7:0]                snap [MEM_BYTES];     // last good run of a pattern
  stream_pkg::addrgen_ctrl_t snap_pat;
  bit                        snap_valid = 1'b0;
  bit                        gnt_random = 1'b0;
  bit                        hung = 1'b0;
  logic [31:0]               rng = 32'h4fbe96f1;
  int                        write_cnt = 0;
  int                        checks = 0;
  int                        errors = 0;

  sink_top dut (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .clear_i         ( clear         ),
    .ctrl_i          ( ctrl          ),
    .flags_o         ( flags         ),
    .beat_i          ( beat          ),
    .beat_valid_i    ( beat_valid    ),
    .beat_ready_o    ( beat_ready    ),
    .mem_req_o       ( mem_req       ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_gnt_i       ( mem_gnt       )
  );

  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // byte k of beat n is n*4+k
  function automatic logic [31:0] beat_word(input int n);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) w[8*k +: 8] = 8'(n * 4 + k);
    return w;
  endfunction

  function automatic test_row_t make_row(input logic [31:0] base, input int tot,
                                         input int d0_len, input int d0_stride,
                                         input int d1_stride, input logic rnd_gnt,
                                         input int clear_at);
    test_row_t r;
    r.pat.base_addr = base;
    r.pat.tot_len   = 16'(tot);
    r.pat.d0_len    = 16'(d0_len);
    r.pat.d0_stride = 16'(d0_stride);
    r.pat.d1_stride = 32'(d1_stride);
    r.rnd_gnt       = rnd_gnt;
    r.clear_at      = 16'(clear_at);
    return r;
  endfunction

  // grant moves 2 ns after the edge like the other inputs
  always @(posedge clk) begin
    #2;
    if (gnt_random) begin
      rng     = xorshift32(rng);
      mem_gnt = rng[1:0] != 2'b00;  // about 3 cycles in 4
    end else begin
      mem_gnt = 1'b1;
    end
  end

  // memory takes a request on req and gnt at the falling edge
  always @(negedge clk) begin
    if (rst_n && mem_req_valid && mem_gnt) begin
      write_cnt++;
      check_value(mem_req.wen, 0, "wen of a store");
      check_value(mem_req.add[1:0], 0, "low bits of add");
      for (int k = 0; k < mem_pkg::MEM_BE_W; k++) begin
        if (mem_req.be[k]) mem[12'(mem_req.add + 32'(k))] = mem_req.data[8*k +: 8];
      end
    end
  end

  task automatic check_value(input int got, input int want, input string what);
    checks++;
    assert (got == want) else begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  // address list from the two-level rule, then the bytes of each beat
  task automatic build_expected(input test_row_t row);
    logic [31:0] line_addr;
    logic [31:0] addr;
    logic [31:0] word;
    int          inner;
    for (int i = 0; i < MEM_BYTES; i++) exp_mem[i] = 8'hee;
    line_addr = row.pat.base_addr;
    inner     = 0;
    for (int n = 0; n < int'(row.pat.tot_len); n++) begin
      addr = line_addr + 32'(inner) * 32'(row.pat.d0_stride);
      word = beat_word(n);
      for (int k = 0; k < 4; k++) exp_mem[12'(addr + 32'(k))] = word[8*k +: 8];
      inner++;
      if (inner == int'(row.pat.d0_len)) begin  // next line
        inner     = 0;
        line_addr = line_addr + row.pat.d1_stride;
      end
    end
  endtask

  task automatic run_test(input int t);
    test_row_t row;
    int        cyc;
    int        sent;
    int        done_cnt;
    int        errs_before;
    bit        cleared;
    bit        finished;
    bit        gen_done_seen;
    row           = tbl[t];
    errs_before   = errors;
    sent          = 0;
    done_cnt      = 0;
    cleared       = 1'b0;
    finished      = 1'b0;
    gen_done_seen = 1'b0;
    cyc           = 0;
    @(negedge clk);
    while (!flags.ready_start && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!flags.ready_start) begin
      $display("Timeout: the sink never became ready for test %0d", t);
      hung = 1'b1;
      return;
    end
    for (int i = 0; i < MEM_BYTES; i++) mem[i] = 8'hee;
    build_expected(row);
    write_cnt  = 0;
    gnt_random = row.rnd_gnt;
    @(posedge clk);
    #2;
    ctrl.req_start    = 1'b1;  // taken on the next edge
    ctrl.addrgen_ctrl = row.pat;
    cyc               = 0;
    while (!finished && cyc < TIMEOUT) begin
      @(posedge clk);
      #2;
      ctrl.req_start = 1'b0;
      clear          = 1'b0;
      if (!cleared && row.clear_at != 0 && sent == int'(row.clear_at)) begin
        clear   = 1'b1;  // abort part way
        cleared = 1'b1;
      end
      beat_valid = !cleared && sent < int'(row.pat.tot_len);
      beat.data  = beat_word(sent);  // held until taken
      beat.strb  = '1;
      @(negedge clk);
      if (beat_valid && beat_ready) sent++;
      if (flags.addrgen_flags.done) gen_done_seen = 1'b1;
      if (flags.done) begin
        done_cnt++;
        check_value(flags.ready_start, 1, "ready_start with done");
        check_value(flags.addrgen_flags.done, 0, "generator done with done");  // cleared on finish
      end
      if (cleared) finished = !clear;  // first cycle after the clear pulse
      else         finished = done_cnt > 0 && !mem_req_valid;  // req fifo drained too
      cyc++;
    end
    if (!finished) begin
      $display("Timeout: test %0d stalled after %0d beats", t, sent);
      hung = 1'b1;
      return;
    end
    if (cleared) begin
      check_value(done_cnt, 0, "done pulses after a clear");
      check_value(flags.ready_start, 1, "ready_start after a clear");
      check_value(mem_req_valid, 0, "mem req after a clear");
    end else begin
      check_value(done_cnt, 1, "done pulses");
      check_value(gen_done_seen, 1, "generator done seen");
      check_value(write_cnt, int'(row.pat.tot_len), "memory writes");
      for (int i = 0; i < MEM_BYTES; i++) begin
        checks++;
        assert (mem[i] == exp_mem[i]) else begin
          $display("Fail at %0t: byte 0x%03h is %02h, expected %02h",
                   $time, i, mem[i], exp_mem[i]);
          errors++;
        end
        if (snap_valid && snap_pat == row.pat) begin  // same pattern under another grant
          checks++;
          assert (mem[i] == snap[i]) else begin
            $display("Fail at %0t: byte 0x%03h is %02h, earlier run of the pattern gave %02h",
                     $time, i, mem[i], snap[i]);
            errors++;
          end
        end
      end
      snap       = mem;
      snap_pat   = row.pat;
      snap_valid = 1'b1;
    end
    $display("test %0d: %0d beats, %0d errors", t, sent, errors - errs_before);
  endtask

  initial begin
    tbl[0] = make_row(32'h100, 8, 8, 4, 32, 1'b0, 0);    // aligned linear
    tbl[1] = make_row(32'h201, 6, 6, 4, 24, 1'b0, 0);    // offset 1
    tbl[2] = make_row(32'h302, 5, 5, 4, 20, 1'b0, 0);    // offset 2
    tbl[3] = make_row(32'h403, 7, 7, 4, 28, 1'b1, 0);    // offset 3 under back-pressure
    tbl[4] = make_row(32'h500, 9, 3, 8, 64, 1'b0, 0);    // two-level
    tbl[5] = make_row(32'h500, 9, 3, 8, 64, 1'b1, 0);    // same pattern under random grant
    tbl[6] = make_row(32'h700, 16, 16, 4, 64, 1'b0, 5);  // cleared at beat 5
    tbl[7] = make_row(32'h100, 8, 8, 4, 32, 1'b0, 0);    // aligned again
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(flags.ready_start, 1, "ready_start after reset");
    check_value(flags.done, 0, "done after reset");
    check_value(mem_req_valid, 0, "mem req after reset");
    for (int t = 0; t < N_TESTS && !hung; t++) run_test(t);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !hung) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/stream_pkg.sv
hdl/mem_pkg.sv
hdl/sink_addressgen.sv
hdl/addr_fifo.sv
hdl/mem_req_fifo.sv
hdl/stream_sink.sv
hdl/sink_top.sv
tests/tb_sink_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_sink_top -o tb_sink_top > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
# a crash or a failed assertion ends the run early
./obj_dir/tb_sink_top > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
